// ==== mem_trace.txt ====
# W sel addr data, R sel addr expect, L first_word count of random words, H idle cycles
# P seg cycle freq_div n, then n expected bytes; all numbers in hex
W 0 0022 000b
W 0 0023 0003
W 0 0024 0000
R 0 0022 000b
R 0 0023 0003
R 0 0024 0000
W 0 0122 5a5a
R 0 0022 000b
R 0 0122 5a5a
W 2 0022 ffff
W 3 0023 ffff
R 0 0022 000b
R 0 0023 0003
R 1 0000 0000
R 2 0022 0000
R 3 0023 0000
W 1 0000 2211
W 1 0001 4433
L 0002 4
W 0 0000 0001
R 0 0000 0001
P 0 000b 0003 4 11 22 33 44
W 0 0020 0001
R 0 0020 0001
W 1 0000 bbaa
W 1 0001 ddcc
L 0002 4
P 0 000b 0003 4 11 22 33 44
W 0 0025 0009
W 0 0026 0004
W 0 0021 0001
R 0 0025 0009
P 1 0009 0004 4 aa bb cc dd
W 0 0000 0000
H 20

// ==== src.f ====
mem_pkg.sv
cpu_bus_bridge.sv
controller_regs.sv
mod_memory.sv
mod_sampler.sv
mem_top.sv
tb_mem_properties.sv
tb_cpu_bus_driver.sv
tb_mem_top.sv

// ==== tb_mem_top.sv ====
`timescale 1ns/1ps
module tb_mem_top
  import mem_pkg::*;
();

  localparam int mod_addr_w = 9;

  logic        CPU_CKIO;
  logic        rst_n;
  logic [16:0] cpu_addr;
  logic [15:0] cpu_data_in;
  logic        cpu_cn;
  logic        cpu_we0_n;
  logic [15:0] cpu_data_out;
  logic [7:0]  mod_value;
  logic [15:0] mod_idx;

  logic [15:0] model_mem [2][2 ** mod_addr_w];  // words as written, per segment.
  logic [7:0]  exp_bytes [64];
  logic        wr_seg = 1'b0;
  logic [31:0] lfsr = 32'heb57;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 100;  // reset and start-up slack.

  mem_top #(.mod_addr_w(mod_addr_w)) u_mem_top (
    .CPU_CKIO     (CPU_CKIO),
    .rst_n        (rst_n),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_data_out (cpu_data_out),
    .mod_value    (mod_value),
    .mod_idx      (mod_idx)
  );

  tb_cpu_bus_driver u_bus_driver (
    .CPU_CKIO     (CPU_CKIO),
    .cpu_data_out (cpu_data_out),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n)
  );

  // the bridge pulse and read word, and the sampler index against its segment's cycle.
  bind mem_top tb_mem_properties u_mem_props (
    .CPU_CKIO  (CPU_CKIO),
    .rst_n     (rst_n),
    .we        (bus.we),
    .data_out  (cpu_data_out),
    .idx       (mod_idx),
    .idx_limit (settings.cycle[mod_rd_segment])
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #2 CPU_CKIO = ~CPU_CKIO;
  end

  always @(posedge CPU_CKIO) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, the trace did not finish", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==============================
  // reference model helpers
  // ==============================

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  task automatic random_word(output logic [15:0] w);
    int i;
    w = '0;
    for (i = 0; i < 16; i++) begin
      w = {w[14:0], lfsr[0]};  // one step per bit taken.
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // even samples sit in the low byte of a word.
  function automatic logic [7:0] model_byte(input int seg, input int idx);
    logic [15:0] w;
    w = model_mem[seg][idx / 2];
    model_byte = (idx % 2 == 1) ? w[15:8] : w[7:0];
  endfunction

  task automatic report_test(input string desc, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests, desc);
    end else begin
      $display("test %0d %s: %0d errors", tests, desc, errors - errs_before);
    end
  endtask

  // ==============================
  // trace commands
  // ==============================

  task automatic write_word(input int sel, input int addr, input int data);
    u_bus_driver.bram_write(sel[1:0], addr[13:0], data[15:0]);
    if (sel[1:0] == bram_select_mod) begin
      model_mem[wr_seg][addr % (2 ** mod_addr_w)] = data[15:0];
    end else if (sel[1:0] == bram_select_controller &&
                 addr[13:0] == {6'd0, addr_mod_mem_wr_segment}) begin
      wr_seg = data[0];
    end
  endtask

  task automatic compare_read(input int sel, input int addr, input int want);
    logic [15:0] got;
    int          errs_before;
    errs_before = errors;
    u_bus_driver.bram_read(sel[1:0], addr[13:0], got);
    checks++;
    if (got !== want[15:0]) begin
      $display("Fail %0t: read %0d:%h returned %h, expected %h", $time, sel, addr[13:0],
               got, want[15:0]);
      errors++;
    end
    report_test($sformatf("read %0d:%h", sel, addr[13:0]), errs_before);
  endtask

  task automatic fill_random(input int addr, input int count);
    logic [15:0] w;
    int          i;
    for (i = 0; i < count; i++) begin
      random_word(w);
      write_word(bram_select_mod, addr + i, w);
    end
  endtask

  task automatic verify_playback(input int seg, input int cycle, input int div, input int n);
    logic [15:0] prev;
    logic [7:0]  want;
    int          k;
    int          gap;
    int          errs_before;
    errs_before = errors;
    @(negedge CPU_CKIO);
    prev = mod_idx;
    @(negedge CPU_CKIO);
    while (!(mod_idx == 16'd0 && prev != 16'd0)) begin  // start on a wrap.
      prev = mod_idx;
      @(negedge CPU_CKIO);
    end
    for (k = 0; k <= cycle; k++) begin
      if (k != 0) begin
        checks++;
        if (mod_idx != k[15:0]) begin
          $display("Fail %0t: mod_idx is %0d, expected %0d", $time, mod_idx, k);
          errors++;
        end
      end
      repeat (2) @(negedge CPU_CKIO);
      want = (k < n) ? exp_bytes[k] : model_byte(seg, k);
      checks++;
      if (mod_value !== want) begin
        $display("Fail %0t: segment %0d sample %0d is %h, expected %h", $time, seg, k,
                 mod_value, want);
        errors++;
      end
      prev = mod_idx;
      gap  = 2;
      while (mod_idx == prev) begin
        @(negedge CPU_CKIO);
        gap++;
      end
      checks++;
      if (gap != div + 1) begin
        $display("Fail %0t: index %0d lasted %0d cycles, expected %0d", $time, k, gap,
                 div + 1);
        errors++;
      end
    end
    checks++;
    if (mod_idx != 16'd0) begin
      $display("Fail %0t: mod_idx went to %0d instead of wrapping to 0", $time, mod_idx);
      errors++;
    end
    report_test($sformatf("playback segment %0d, %0d samples", seg, cycle + 1), errs_before);
  endtask

  task automatic watch_idle(input int cycles);
    int i;
    int errs_before;
    errs_before = errors;
    for (i = 0; i < cycles; i++) begin
      @(negedge CPU_CKIO);
      checks++;
      if (mod_idx != 16'd0) begin
        $display("Fail %0t: mod_idx is %0d with playback disabled", $time, mod_idx);
        errors++;
      end
    end
    report_test($sformatf("idle for %0d cycles", cycles), errs_before);
  endtask

  task automatic run_trace(input int fd);
    byte   cmd;
    int    a;
    int    b;
    int    c;
    int    n;
    int    k;
    int    val;
    string line;
    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": void'($fgets(line, fd));
        "W": begin
          void'($fscanf(fd, "%h %h %h", a, b, c));
          cycle_limit += 12;
          write_word(a, b, c);
        end
        "R": begin
          void'($fscanf(fd, "%h %h %h", a, b, c));
          cycle_limit += 12;
          compare_read(a, b, c);
        end
        "L": begin
          void'($fscanf(fd, "%h %h", a, b));
          cycle_limit += 12 * b;
          fill_random(a, b);
        end
        "P": begin
          void'($fscanf(fd, "%h %h %h %h", a, b, c, n));
          for (k = 0; k < n; k++) begin
            void'($fscanf(fd, "%h", val));
            exp_bytes[k] = val[7:0];
          end
          cycle_limit += 3 * (b + 1) * (c + 1) + 12;  // up to two passes plus the wrap.
          verify_playback(a, b, c, n);
        end
        "H": begin
          void'($fscanf(fd, "%h", a));
          cycle_limit += a + 12;
          watch_idle(a);
        end
        default: begin
          $display("unknown command %c in mem_trace.txt, rest of the line skipped", cmd);
          void'($fgets(line, fd));
          errors++;
        end
      endcase
    end
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    int fd;
    rst_n = 1'b0;
    repeat (4) @(posedge CPU_CKIO);
    rst_n <= 1'b1;
    fd = $fopen("mem_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open mem_trace.txt, no tests were run");
      errors++;
    end else begin
      run_trace(fd);
      $fclose(fd);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb_cpu_bus_driver.sv ====
`timescale 1ns/1ps
module tb_cpu_bus_driver (
  input  logic        CPU_CKIO,
  input  logic [15:0] cpu_data_out,
  output logic [16:0] cpu_addr,
  output logic [15:0] cpu_data_in,
  output logic        cpu_cn,
  output logic        cpu_we0_n
);

  initial begin
    cpu_addr    = '0;
    cpu_data_in = '0;
    cpu_cn      = 1'b1;
    cpu_we0_n   = 1'b1;
  end

  // ==============================
  // bus cycles
  // ==============================

  // write strobe stays low for two cycles inside the chip enable.
  task automatic bram_write(input logic [1:0] select, input logic [13:0] addr,
                            input logic [15:0] data);
    @(posedge CPU_CKIO);
    cpu_addr    <= {select, addr, 1'b0};  // bit 0 is the byte bit.
    cpu_data_in <= data;
    cpu_cn      <= 1'b0;
    @(posedge CPU_CKIO);
    cpu_we0_n <= 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    cpu_we0_n <= 1'b1;
    @(posedge CPU_CKIO);
    cpu_cn <= 1'b1;
  endtask

  task automatic bram_read(input logic [1:0] select, input logic [13:0] addr,
                           output logic [15:0] data);
    @(posedge CPU_CKIO);
    cpu_addr <= {select, addr, 1'b0};
    cpu_cn   <= 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    data = cpu_data_out;  // settled two edges after the chip enable fell.
    @(posedge CPU_CKIO);
    cpu_cn <= 1'b1;
  endtask

endmodule

// ==== tb_mem_properties.sv ====
`timescale 1ns/1ps
module tb_mem_properties (
  input logic        CPU_CKIO,
  input logic        rst_n,
  input logic        we,
  input logic [15:0] data_out,
  input logic [15:0] idx,
  input logic [15:0] idx_limit
);

  // one access gives one write pulse.
  assert property (@(posedge CPU_CKIO) disable iff (!rst_n) we |=> !we)
    else $error("bus write pulse stayed high for two cycles");

  assert property (@(posedge CPU_CKIO) !rst_n |=> data_out == 16'd0)
    else $error("cpu read data is not zero during reset");

  assert property (@(posedge CPU_CKIO) disable iff (!rst_n) idx <= idx_limit)
    else $error("playback index went past the segment cycle");

endmodule

// ==== mem_top.sv ====
`timescale 1ns/1ps
module mem_top
  import mem_pkg::*;
#(
  parameter int mod_addr_w = 9
) (
  input  logic        CPU_CKIO,
  input  logic        rst_n,
  input  logic [16:0] cpu_addr,
  input  logic [15:0] cpu_data_in,
  input  logic        cpu_cn,
  input  logic        cpu_we0_n,
  output logic [15:0] cpu_data_out,
  output logic [7:0]  mod_value,
  output logic [15:0] mod_idx
);

  mem_bus_t            bus;
  ctl_addr_u           rd_addr;
  logic [15:0]         rd_data;
  mod_settings_t       settings;
  logic                mod_rd_segment;
  logic [mod_addr_w:0] mod_rd_addr;
  logic [7:0]          mod_rd_byte;

  cpu_bus_bridge u_cpu_bus_bridge (
    .CPU_CKIO     (CPU_CKIO),
    .rst_n        (rst_n),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n),
    .rd_data      (rd_data),
    .bus          (bus),
    .rd_addr      (rd_addr),
    .cpu_data_out (cpu_data_out)
  );

  controller_regs u_controller_regs (
    .CPU_CKIO (CPU_CKIO),
    .rst_n    (rst_n),
    .bus      (bus),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .settings (settings)
  );

  mod_memory #(.mod_addr_w(mod_addr_w)) u_mod_memory (
    .CPU_CKIO   (CPU_CKIO),
    .bus        (bus),
    .wr_segment (settings.wr_segment),
    .rd_segment (mod_rd_segment),
    .rd_addr    (mod_rd_addr),
    .rd_byte    (mod_rd_byte)
  );

  mod_sampler #(.mod_addr_w(mod_addr_w)) u_mod_sampler (
    .CPU_CKIO   (CPU_CKIO),
    .rst_n      (rst_n),
    .settings   (settings),
    .rd_byte    (mod_rd_byte),
    .rd_segment (mod_rd_segment),
    .rd_addr    (mod_rd_addr),
    .mod_value  (mod_value),
    .mod_idx    (mod_idx)
  );

endmodule

// ==== mod_sampler.sv ====
`timescale 1ns/1ps
module mod_sampler
  import mem_pkg::*;
#(
  parameter int mod_addr_w = 9
) (
  input  logic                CPU_CKIO,
  input  logic                rst_n,
  input  mod_settings_t       settings,
  input  logic [7:0]          rd_byte,
  output logic                rd_segment,
  output logic [mod_addr_w:0] rd_addr,
  output logic [7:0]          mod_value,
  output logic [15:0]         mod_idx
);

  logic [31:0] div_cnt;
  logic [15:0] idx;
  logic        seg;
  logic [31:0] div_lim;
  logic [15:0] cycle_lim;

  assign div_lim   = settings.freq_div[seg];
  assign cycle_lim = settings.cycle[seg];

  // ==============================
  // divider and index
  // ==============================

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      idx     <= '0;
      seg     <= 1'b0;
    end else if (!settings.enable) begin
      div_cnt <= '0;
      idx     <= '0;
      seg     <= settings.req_rd_segment;  // stopped at index 0, so a new segment is safe.
    end else if (div_cnt >= div_lim) begin
      div_cnt <= '0;
      if (idx >= cycle_lim) begin
        idx <= '0;
        seg <= settings.req_rd_segment;  // segment changes only at the wrap.
      end else begin
        idx <= idx + 16'd1;
      end
    end else begin
      div_cnt <= div_cnt + 32'd1;
    end
  end

  assign rd_segment = seg;
  assign rd_addr    = idx[mod_addr_w:0];
  assign mod_idx    = idx;

  // memory adds one cycle, this register the second.
  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      mod_value <= '0;
    end else begin
      mod_value <= rd_byte;
    end
  end

endmodule

// ==== mod_memory.sv ====
`timescale 1ns/1ps
module mod_memory
  import mem_pkg::*;
#(
  parameter int mod_addr_w = 9
) (
  input  logic                CPU_CKIO,
  input  mem_bus_t            bus,
  input  logic                wr_segment,
  input  logic                rd_segment,
  input  logic [mod_addr_w:0] rd_addr,
  output logic [7:0]          rd_byte
);

  localparam int depth = 2 ** (mod_addr_w + 1);  // both segments, in 16-bit words.

  logic [15:0] mem [depth];
  logic [15:0] word_q;
  logic        byte_sel_q;
  logic        wr_en;

  assign wr_en = bus.we && (bus.select == bram_select_mod);

  // the segment bit sits on top of the word address.
  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[{wr_segment, bus.addr.raw[mod_addr_w-1:0]}] <= bus.data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    word_q     <= mem[{rd_segment, rd_addr[mod_addr_w:1]}];
    byte_sel_q <= rd_addr[0];
  end

  // even samples live in the low byte.
  assign rd_byte = byte_sel_q ? word_q[15:8] : word_q[7:0];

endmodule

// ==== controller_regs.sv ====
`timescale 1ns/1ps
module controller_regs
  import mem_pkg::*;
(
  input  logic          CPU_CKIO,
  input  logic          rst_n,
  input  mem_bus_t      bus,
  input  ctl_addr_u     rd_addr,
  output logic [15:0]   rd_data,
  output mod_settings_t settings
);

  logic [15:0] ctl_flag;
  logic [15:0] mem_wr_segment;
  logic [15:0] req_rd_segment;
  logic [15:0] cycle0;
  logic [15:0] freq_div0_0;
  logic [15:0] freq_div0_1;
  logic [15:0] cycle1;
  logic [15:0] freq_div1_0;
  logic [15:0] freq_div1_1;
  logic [15:0] clk_mem [32][3];  // clock table, three words per entry.
  logic        wr_main;
  logic        wr_clock;
  logic [15:0] main_rd;
  logic [15:0] clock_rd;

  assign wr_main = bus.we && (bus.select == bram_select_controller) &&
                   (bus.addr.fields.cnt_select == cnt_select_main);
  assign wr_clock = bus.we && (bus.select == bram_select_controller) &&
                    (bus.addr.fields.cnt_select == cnt_select_clock);

  // ==============================
  // main page
  // ==============================

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      ctl_flag       <= '0;
      mem_wr_segment <= '0;
      req_rd_segment <= '0;
      cycle0         <= '0;
      freq_div0_0    <= '0;
      freq_div0_1    <= '0;
      cycle1         <= '0;
      freq_div1_0    <= '0;
      freq_div1_1    <= '0;
    end else if (wr_main) begin
      case (bus.addr.fields.reg_addr)
        addr_ctl_flag:           ctl_flag <= bus.data;
        addr_mod_mem_wr_segment: mem_wr_segment <= bus.data;
        addr_mod_req_rd_segment: req_rd_segment <= bus.data;
        addr_mod_cycle0:         cycle0 <= bus.data;
        addr_mod_freq_div0_0:    freq_div0_0 <= bus.data;
        addr_mod_freq_div0_1:    freq_div0_1 <= bus.data;
        addr_mod_cycle1:         cycle1 <= bus.data;
        addr_mod_freq_div1_0:    freq_div1_0 <= bus.data;
        addr_mod_freq_div1_1:    freq_div1_1 <= bus.data;
        default: ;  // unmapped addresses are ignored.
      endcase
    end
  end

  always_comb begin
    case (rd_addr.fields.reg_addr)
      addr_ctl_flag:           main_rd = ctl_flag;
      addr_mod_mem_wr_segment: main_rd = mem_wr_segment;
      addr_mod_req_rd_segment: main_rd = req_rd_segment;
      addr_mod_cycle0:         main_rd = cycle0;
      addr_mod_freq_div0_0:    main_rd = freq_div0_0;
      addr_mod_freq_div0_1:    main_rd = freq_div0_1;
      addr_mod_cycle1:         main_rd = cycle1;
      addr_mod_freq_div1_0:    main_rd = freq_div1_0;
      addr_mod_freq_div1_1:    main_rd = freq_div1_1;
      default:                 main_rd = '0;
    endcase
  end

  // ==============================
  // clock page
  // ==============================

  // reg_addr is {0, entry[4:0], word[1:0]}.
  always_ff @(posedge CPU_CKIO) begin
    if (wr_clock && !bus.addr.fields.reg_addr[7] && (bus.addr.fields.reg_addr[1:0] != 2'd3)) begin
      clk_mem[bus.addr.fields.reg_addr[6:2]][bus.addr.fields.reg_addr[1:0]] <= bus.data;
    end
  end

  always_comb begin
    if (!rd_addr.fields.reg_addr[7] && (rd_addr.fields.reg_addr[1:0] != 2'd3)) begin
      clock_rd = clk_mem[rd_addr.fields.reg_addr[6:2]][rd_addr.fields.reg_addr[1:0]];
    end else begin
      clock_rd = '0;
    end
  end

  always_comb begin
    case (rd_addr.fields.cnt_select)
      cnt_select_main:  rd_data = main_rd;
      cnt_select_clock: rd_data = clock_rd;
      default:          rd_data = '0;
    endcase
  end

  assign settings.wr_segment     = mem_wr_segment[0];
  assign settings.req_rd_segment = req_rd_segment[0];
  assign settings.cycle[0]       = cycle0;
  assign settings.cycle[1]       = cycle1;
  assign settings.freq_div[0]    = {freq_div0_1, freq_div0_0};
  assign settings.freq_div[1]    = {freq_div1_1, freq_div1_0};
  assign settings.enable         = ctl_flag[0];

endmodule

// ==== cpu_bus_bridge.sv ====
`timescale 1ns/1ps
module cpu_bus_bridge
  import mem_pkg::*;
(
  input  logic        CPU_CKIO,
  input  logic        rst_n,
  input  logic [16:0] cpu_addr,
  input  logic [15:0] cpu_data_in,
  input  logic        cpu_cn,
  input  logic        cpu_we0_n,
  input  logic [15:0] rd_data,
  output mem_bus_t    bus,
  output ctl_addr_u   rd_addr,
  output logic [15:0] cpu_data_out
);

  logic        cn_q;
  logic        we_n_q;
  logic        we_q;
  logic [16:1] addr_q;  // bit 0 selects a byte and is not needed here.
  logic [15:0] data_q;
  logic        rd_load;

  // ==============================
  // strobe sampling
  // ==============================

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      cn_q   <= 1'b1;
      we_n_q <= 1'b1;
      we_q   <= 1'b0;
    end else begin
      cn_q   <= cpu_cn;
      we_n_q <= cpu_we0_n;
      we_q   <= ~cpu_cn & ~cpu_we0_n & we_n_q;  // falling edge of the write strobe.
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr[16:1];
    data_q <= cpu_data_in;
  end

  assign bus.we       = we_q;
  assign bus.select   = addr_q[16:15];
  assign bus.addr.raw = addr_q[14:1];
  assign bus.data     = data_q;

  assign rd_addr.raw = addr_q[14:1];

  // ==============================
  // read return
  // ==============================

  // the register bank answers combinationally, so the word is taken one edge later.
  assign rd_load = ~cn_q & we_n_q;

  always_ff @(posedge CPU_CKIO or negedge rst_n) begin
    if (!rst_n) begin
      cpu_data_out <= '0;
    end else if (rd_load) begin
      if (addr_q[16:15] == bram_select_controller) begin
        cpu_data_out <= rd_data;
      end else begin
        cpu_data_out <= '0;  // only the controller region is readable.
      end
    end
  end

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

  // ==============================
  // bus and page selects
  // ==============================

  localparam logic [1:0] bram_select_controller = 2'd0;
  localparam logic [1:0] bram_select_mod = 2'd1;
  localparam logic [1:0] bram_select_duty_table = 2'd2;
  localparam logic [1:0] bram_select_stm = 2'd3;

  localparam logic [1:0] cnt_select_main = 2'd0;
  localparam logic [1:0] cnt_select_clock = 2'd1;

  // ==============================
  // main page register map
  // ==============================

  localparam logic [7:0] addr_ctl_flag = 8'h00;
  localparam logic [7:0] addr_mod_mem_wr_segment = 8'h20;
  localparam logic [7:0] addr_mod_req_rd_segment = 8'h21;
  localparam logic [7:0] addr_mod_cycle0 = 8'h22;
  localparam logic [7:0] addr_mod_freq_div0_0 = 8'h23;  // low half of the divider.
  localparam logic [7:0] addr_mod_freq_div0_1 = 8'h24;
  localparam logic [7:0] addr_mod_cycle1 = 8'h25;
  localparam logic [7:0] addr_mod_freq_div1_0 = 8'h26;
  localparam logic [7:0] addr_mod_freq_div1_1 = 8'h27;

  // ==============================
  // bus and settings types
  // ==============================

  // one memory word address, seen either whole or as controller fields.
  typedef union packed {
    logic [13:0] raw;
    struct packed {
      logic [3:0] pad;
      logic [1:0] cnt_select;
      logic [7:0] reg_addr;
    } fields;
  } ctl_addr_u;

  typedef struct packed {
    logic       we;  // single cycle write pulse.
    logic [1:0] select;
    ctl_addr_u  addr;
    logic [15:0] data;
  } mem_bus_t;

  typedef struct packed {
    logic             wr_segment;
    logic             req_rd_segment;
    logic [1:0][15:0] cycle;  // last index of each segment.
    logic [1:0][31:0] freq_div;
    logic             enable;
  } mod_settings_t;

endpackage
